/* include/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// RV32I datapath sizing
`define XLEN       32
`define REG_COUNT  32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC   32'h0000_0000
// addi x0, x0, 0
`define NOP_INSTR  32'h0000_0013

`endif

/* logic/rv_isa_pkg.sv */
`include "rv_params.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [31:0]            instr_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0]             byte_en_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_e;

  // load and store width field
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_funct3_e;

  // funct3 of register and immediate arithmetic
  typedef enum logic [2:0] {
    f3_add  = 3'b000,
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } arith_funct3_e;

endpackage

/* logic/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // operation selected in decode, carried to the execute ALU
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // lui passes the upper immediate straight through
    alu_pass_b = 4'd10
  } alu_op_e;

  // source of the value written back to the register file
  typedef enum logic {
    wb_alu = 1'b0,
    wb_mem = 1'b1
  } wb_sel_e;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall,
  input  logic               redirect,
  input  rv_isa_pkg::word_t  redirect_pc,
  input  rv_isa_pkg::instr_t imem_rdata,
  output rv_isa_pkg::word_t  imem_addr,
  output rv_isa_pkg::instr_t ifid_instr,
  output rv_isa_pkg::word_t  ifid_pc
);
  import rv_isa_pkg::*;

  word_t pc;
  word_t pc_next;

  assign imem_addr = pc;

  // redirect from execute beats a load-use hold
  always_comb begin
    if (redirect) pc_next = redirect_pc;
    else if (stall) pc_next = pc;
    else pc_next = pc + word_t'(4);
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= `RESET_PC;
    else pc <= pc_next;
  end

  // fetch/decode register, squashed to a nop on redirect
  always_ff @(posedge clk) begin
    if (rst || redirect) ifid_instr <= `NOP_INSTR;
    else if (!stall) ifid_instr <= imem_rdata;
  end

  always_ff @(posedge clk) begin
    if (!stall || redirect) ifid_pc <= pc;
  end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::instr_t     ifid_instr,
  input  rv_isa_pkg::word_t      ifid_pc,
  input  logic                   redirect,
  input  logic                   wb_en,
  input  rv_isa_pkg::reg_addr_t  wb_rd,
  input  rv_isa_pkg::word_t      wb_data,
  output logic                   stall,
  output rv_isa_pkg::word_t      id_pc,
  output rv_isa_pkg::reg_addr_t  id_rs1,
  output rv_isa_pkg::reg_addr_t  id_rs2,
  output rv_isa_pkg::word_t      id_rs1_val,
  output rv_isa_pkg::word_t      id_rs2_val,
  output rv_isa_pkg::word_t      id_imm,
  output rv_isa_pkg::reg_addr_t  id_rd,
  output rv_pipe_pkg::alu_op_e   id_alu_op,
  output logic                   id_use_imm,
  output logic                   id_reg_write,
  output logic                   id_is_load,
  output logic                   id_is_store,
  output logic                   id_is_branch,
  output logic [2:0]             id_funct3
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t     regs [`REG_COUNT];
  opcode_e   opcode;
  reg_addr_t rs1, rs2, rd;
  logic [2:0] funct3;
  word_t     imm_i, imm_s, imm_b, imm_u;
  word_t     rs1_val, rs2_val;
  // decoded control
  logic      dec_valid;
  alu_op_e   dec_alu_op;
  logic      dec_use_imm, dec_reg_write, dec_is_load, dec_is_store, dec_is_branch;
  logic      uses_rs1, uses_rs2;
  word_t     dec_imm;

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (arith_funct3_e'(f3))
      f3_add:  return alt ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return alt ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // register zero reads zero and a same-cycle writeback goes straight through
  function automatic word_t read_reg(input reg_addr_t addr);
    if (addr == '0) return '0;
    if (wb_en && (wb_rd == addr)) return wb_data;
    return regs[addr];
  endfunction

  //**************************************************
  // field extraction

  assign opcode = opcode_e'(ifid_instr[6:0]);
  assign rd     = ifid_instr[11:7];
  assign funct3 = ifid_instr[14:12];
  assign rs1    = ifid_instr[19:15];
  assign rs2    = ifid_instr[24:20];

  assign imm_i = {{(`XLEN-11){ifid_instr[31]}}, ifid_instr[30:20]};
  assign imm_s = {{(`XLEN-11){ifid_instr[31]}}, ifid_instr[30:25], ifid_instr[11:7]};
  assign imm_b = {{(`XLEN-12){ifid_instr[31]}}, ifid_instr[7], ifid_instr[30:25],
                  ifid_instr[11:8], 1'b0};
  assign imm_u = {ifid_instr[31:12], 12'h000};

  //**************************************************
  // control generation

  always_comb begin
    dec_valid     = 1'b1;
    dec_alu_op    = alu_add;
    dec_use_imm   = 1'b0;
    dec_reg_write = 1'b0;
    dec_is_load   = 1'b0;
    dec_is_store  = 1'b0;
    dec_is_branch = 1'b0;
    dec_imm       = imm_i;
    uses_rs1      = 1'b1;
    uses_rs2      = 1'b0;
    case (opcode)
      op_reg: begin
        dec_alu_op    = arith_op(funct3, ifid_instr[30]);
        dec_reg_write = 1'b1;
        uses_rs2      = 1'b1;
      end
      op_imm: begin
        // bit 30 selects sra only for shifts and is immediate elsewhere
        dec_alu_op    = arith_op(funct3, (funct3 == f3_sr) && ifid_instr[30]);
        dec_use_imm   = 1'b1;
        dec_reg_write = 1'b1;
      end
      op_lui: begin
        dec_alu_op    = alu_pass_b;
        dec_use_imm   = 1'b1;
        dec_imm       = imm_u;
        dec_reg_write = 1'b1;
        uses_rs1      = 1'b0;
      end
      op_load: begin
        dec_use_imm   = 1'b1;
        dec_reg_write = 1'b1;
        dec_is_load   = 1'b1;
      end
      op_store: begin
        dec_use_imm  = 1'b1;
        dec_imm      = imm_s;
        dec_is_store = 1'b1;
        uses_rs2     = 1'b1;
      end
      op_br: begin
        dec_alu_op    = alu_sub;
        dec_imm       = imm_b;
        dec_is_branch = 1'b1;
        uses_rs2      = 1'b1;
      end
      default: begin
        dec_valid = 1'b0;
        uses_rs1  = 1'b0;
      end
    endcase
  end

  //**************************************************
  // register file

  always_ff @(posedge clk) begin
    if (wb_en && (wb_rd != '0)) regs[wb_rd] <= wb_data;
  end

  always_comb begin
    rs1_val = read_reg(rs1);
    rs2_val = read_reg(rs2);
  end

  // load in execute feeding the instruction now in decode
  assign stall = id_is_load && (id_rd != '0) &&
                 ((uses_rs1 && (rs1 == id_rd)) || (uses_rs2 && (rs2 == id_rd)));

  // decode/execute register
  always_ff @(posedge clk) begin
    if (rst || redirect || stall || !dec_valid) begin
      id_reg_write <= 1'b0;
      id_is_load   <= 1'b0;
      id_is_store  <= 1'b0;
      id_is_branch <= 1'b0;
    end else begin
      id_reg_write <= dec_reg_write;
      id_is_load   <= dec_is_load;
      id_is_store  <= dec_is_store;
      id_is_branch <= dec_is_branch;
    end
  end

  always_ff @(posedge clk) begin
    id_pc      <= ifid_pc;
    id_rs1     <= rs1;
    id_rs2     <= rs2;
    id_rs1_val <= rs1_val;
    id_rs2_val <= rs2_val;
    id_imm     <= dec_imm;
    id_rd      <= rd;
    id_alu_op  <= dec_alu_op;
    id_use_imm <= dec_use_imm;
    id_funct3  <= funct3;
  end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::word_t      id_pc,
  input  rv_isa_pkg::reg_addr_t  id_rs1,
  input  rv_isa_pkg::reg_addr_t  id_rs2,
  input  rv_isa_pkg::word_t      id_rs1_val,
  input  rv_isa_pkg::word_t      id_rs2_val,
  input  rv_isa_pkg::word_t      id_imm,
  input  rv_isa_pkg::reg_addr_t  id_rd,
  input  rv_pipe_pkg::alu_op_e   id_alu_op,
  input  logic                   id_use_imm,
  input  logic                   id_reg_write,
  input  logic                   id_is_load,
  input  logic                   id_is_store,
  input  logic                   id_is_branch,
  input  logic [2:0]             id_funct3,
  input  logic                   wb_en,
  input  rv_isa_pkg::reg_addr_t  wb_rd,
  input  rv_isa_pkg::word_t      wb_data,
  output logic                   redirect,
  output rv_isa_pkg::word_t      redirect_pc,
  output rv_isa_pkg::word_t      ex_result,
  output rv_isa_pkg::word_t      ex_store_val,
  output rv_isa_pkg::reg_addr_t  ex_rd,
  output logic                   ex_reg_write,
  output logic                   ex_is_load,
  output logic                   ex_is_store,
  output logic [2:0]             ex_funct3
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_result;
  logic  cond_true;

  // newest producer first; a load in memory has no data yet
  function automatic word_t forward(input reg_addr_t rs, input word_t reg_val);
    if ((rs != '0) && ex_reg_write && !ex_is_load && (ex_rd == rs)) return ex_result;
    if ((rs != '0) && wb_en && (wb_rd == rs)) return wb_data;
    return reg_val;
  endfunction

  always_comb begin
    op_a = forward(id_rs1, id_rs1_val);
    op_b = forward(id_rs2, id_rs2_val);
  end

  assign alu_b = id_use_imm ? id_imm : op_b;

  //**************************************************
  // ALU

  always_comb begin
    case (id_alu_op)
      alu_add:    alu_result = op_a + alu_b;
      alu_sub:    alu_result = op_a - alu_b;
      alu_sll:    alu_result = op_a << alu_b[4:0];
      alu_slt:    alu_result = word_t'($signed(op_a) < $signed(alu_b));
      alu_sltu:   alu_result = word_t'(op_a < alu_b);
      alu_xor:    alu_result = op_a ^ alu_b;
      alu_srl:    alu_result = op_a >> alu_b[4:0];
      alu_sra:    alu_result = word_t'($signed(op_a) >>> alu_b[4:0]);
      alu_or:     alu_result = op_a | alu_b;
      alu_and:    alu_result = op_a & alu_b;
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // branch condition on the forwarded register operands
  always_comb begin
    case (branch_funct3_e'(id_funct3))
      beq:     cond_true = (op_a == op_b);
      bne:     cond_true = (op_a != op_b);
      blt:     cond_true = ($signed(op_a) < $signed(op_b));
      bge:     cond_true = ($signed(op_a) >= $signed(op_b));
      bltu:    cond_true = (op_a < op_b);
      bgeu:    cond_true = (op_a >= op_b);
      default: cond_true = 1'b0;
    endcase
  end

  // taken branch squashes fetch/decode and the decode/execute register
  assign redirect    = id_is_branch && cond_true;
  assign redirect_pc = id_pc + id_imm;

  //**************************************************
  // execute/memory register

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_reg_write <= 1'b0;
      ex_is_load   <= 1'b0;
      ex_is_store  <= 1'b0;
    end else begin
      ex_reg_write <= id_reg_write;
      ex_is_load   <= id_is_load;
      ex_is_store  <= id_is_store;
    end
  end

  always_ff @(posedge clk) begin
    ex_result    <= alu_result;
    ex_store_val <= op_b;
    ex_rd        <= id_rd;
    ex_funct3    <= id_funct3;
  end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module memory_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::word_t      ex_result,
  input  rv_isa_pkg::word_t      ex_store_val,
  input  rv_isa_pkg::reg_addr_t  ex_rd,
  input  logic                   ex_reg_write,
  input  logic                   ex_is_load,
  input  logic                   ex_is_store,
  input  logic [2:0]             ex_funct3,
  input  rv_isa_pkg::word_t      dmem_rdata,
  output logic                   dmem_read,
  output logic                   dmem_write,
  output rv_isa_pkg::word_t      dmem_addr,
  output rv_isa_pkg::word_t      dmem_wdata,
  output rv_isa_pkg::byte_en_t   dmem_mbe,
  output logic                   wb_en,
  output rv_isa_pkg::reg_addr_t  wb_rd,
  output rv_isa_pkg::word_t      wb_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [1:0] offset;
  word_t      rdata_shifted;
  word_t      load_data;
  wb_sel_e    wb_sel;
  word_t      wb_alu_val;
  word_t      wb_mem_val;

  assign offset     = ex_result[1:0];
  assign dmem_addr  = {ex_result[`XLEN-1:2], 2'b00};
  assign dmem_read  = ex_is_load;
  assign dmem_write = ex_is_store;

  // store data and enables moved into the addressed lanes
  always_comb begin
    dmem_wdata = ex_store_val << {offset, 3'b000};
    case (mem_funct3_e'(ex_funct3))
      mem_b:   dmem_mbe = byte_en_t'(4'b0001) << offset;
      mem_h:   dmem_mbe = byte_en_t'(4'b0011) << offset;
      default: dmem_mbe = 4'b1111;
    endcase
  end

  // load lane extraction and extension
  assign rdata_shifted = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem_funct3_e'(ex_funct3))
      mem_b:   load_data = {{(`XLEN-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      mem_bu:  load_data = {{(`XLEN-8){1'b0}}, rdata_shifted[7:0]};
      mem_h:   load_data = {{(`XLEN-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      mem_hu:  load_data = {{(`XLEN-16){1'b0}}, rdata_shifted[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

  //**************************************************
  // memory/writeback register

  always_ff @(posedge clk) begin
    if (rst) wb_en <= 1'b0;
    else wb_en <= ex_reg_write;
  end

  always_ff @(posedge clk) begin
    wb_rd      <= ex_rd;
    wb_sel     <= ex_is_load ? wb_mem : wb_alu;
    wb_alu_val <= ex_result;
    wb_mem_val <= load_data;
  end

  assign wb_data = (wb_sel == wb_mem) ? wb_mem_val : wb_alu_val;

endmodule

/* logic/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  output rv_isa_pkg::word_t     imem_addr,
  input  rv_isa_pkg::instr_t    imem_rdata,
  output logic                  dmem_read,
  output logic                  dmem_write,
  output rv_isa_pkg::word_t     dmem_addr,
  output rv_isa_pkg::word_t     dmem_wdata,
  output rv_isa_pkg::byte_en_t  dmem_mbe,
  input  rv_isa_pkg::word_t     dmem_rdata
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // stage to stage control
  logic      stall;
  logic      redirect;
  word_t     redirect_pc;
  // fetch/decode
  instr_t    ifid_instr;
  word_t     ifid_pc;
  // decode/execute
  word_t     id_pc, id_rs1_val, id_rs2_val, id_imm;
  reg_addr_t id_rs1, id_rs2, id_rd;
  alu_op_e   id_alu_op;
  logic      id_use_imm, id_reg_write, id_is_load, id_is_store, id_is_branch;
  logic [2:0] id_funct3;
  // execute/memory
  word_t     ex_result, ex_store_val;
  reg_addr_t ex_rd;
  logic      ex_reg_write, ex_is_load, ex_is_store;
  logic [2:0] ex_funct3;
  // writeback
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;

  fetch_stage i_fetch (
    .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .imem_rdata(imem_rdata), .imem_addr(imem_addr),
    .ifid_instr(ifid_instr), .ifid_pc(ifid_pc)
  );

  decode_stage i_decode (
    .clk(clk), .rst(rst), .ifid_instr(ifid_instr), .ifid_pc(ifid_pc),
    .redirect(redirect), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .stall(stall), .id_pc(id_pc), .id_rs1(id_rs1), .id_rs2(id_rs2),
    .id_rs1_val(id_rs1_val), .id_rs2_val(id_rs2_val), .id_imm(id_imm),
    .id_rd(id_rd), .id_alu_op(id_alu_op), .id_use_imm(id_use_imm),
    .id_reg_write(id_reg_write), .id_is_load(id_is_load),
    .id_is_store(id_is_store), .id_is_branch(id_is_branch), .id_funct3(id_funct3)
  );

  execute_stage i_execute (
    .clk(clk), .rst(rst), .id_pc(id_pc), .id_rs1(id_rs1), .id_rs2(id_rs2),
    .id_rs1_val(id_rs1_val), .id_rs2_val(id_rs2_val), .id_imm(id_imm),
    .id_rd(id_rd), .id_alu_op(id_alu_op), .id_use_imm(id_use_imm),
    .id_reg_write(id_reg_write), .id_is_load(id_is_load),
    .id_is_store(id_is_store), .id_is_branch(id_is_branch), .id_funct3(id_funct3),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .ex_result(ex_result), .ex_store_val(ex_store_val), .ex_rd(ex_rd),
    .ex_reg_write(ex_reg_write), .ex_is_load(ex_is_load),
    .ex_is_store(ex_is_store), .ex_funct3(ex_funct3)
  );

  memory_stage i_memory (
    .clk(clk), .rst(rst), .ex_result(ex_result), .ex_store_val(ex_store_val),
    .ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_is_load(ex_is_load),
    .ex_is_store(ex_is_store), .ex_funct3(ex_funct3), .dmem_rdata(dmem_rdata),
    .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_mbe(dmem_mbe),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
  );

endmodule

/* testbench/rv_core_chk.sv */
`timescale 1ns/10ps

module rv_core_chk (
  input logic                 clk,
  input logic                 rst,
  input logic                 dmem_read,
  input logic                 dmem_write,
  input rv_isa_pkg::word_t    dmem_addr,
  input rv_isa_pkg::byte_en_t dmem_mbe
);

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // one access per memory-stage cycle
  strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(dmem_read && dmem_write))
    else begin
      $error("dmem_read and dmem_write high in the same cycle");
      fail_count++;
    end

  write_has_lanes: assert property (@(posedge clk) disable iff (rst)
    dmem_write |-> (dmem_mbe != 4'b0000))
    else begin
      $error("dmem_write with no byte enabled");
      fail_count++;
    end

  // memory stage always presents a word address
  addr_aligned: assert property (@(posedge clk) disable iff (rst)
    (dmem_read || dmem_write) |-> (dmem_addr[1:0] == 2'b00))
    else begin
      $error("dmem_addr not word aligned during an access");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!dmem_read && !dmem_write))
    else begin
      $error("data strobe high in the cycle after reset");
      fail_count++;
    end

endmodule

bind rv_core rv_core_chk i_rv_core_chk (
  .clk(clk), .rst(rst), .dmem_read(dmem_read), .dmem_write(dmem_write),
  .dmem_addr(dmem_addr), .dmem_mbe(dmem_mbe)
);

/* testbench/rv_core_tb.sv */
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core_tb;
  import rv_isa_pkg::*;

  logic     clk;
  logic     rst;
  word_t    imem_addr;
  instr_t   imem_rdata;
  logic     dmem_read;
  logic     dmem_write;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  byte_en_t dmem_mbe;
  word_t    dmem_rdata;

  instr_t imem [256];
  word_t  dmem [1024];
  // expected memory and register contents
  word_t  ref_mem [1024];
  word_t  model [32];
  int     prog_len;
  int     load_count;
  word_t  lcg_state = 32'h83c85e87;
  int     tests = 0;
  int     checks = 0;
  int     errors = 0;
  int     test_errors = 0;

  rv_core i_rv_core (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_mbe(dmem_mbe), .dmem_rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //**************************************************
  // memory models

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (dmem_write) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_mbe[i]) dmem[dmem_addr[11:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
      end
    end
  end

  function automatic word_t rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t fill_word(input int i);
    return (i + 1) * 32'h9e37_79b9;
  endfunction

  //**************************************************
  // instruction encoders

  function automatic instr_t enc_r(input logic [2:0] f3, input logic alt,
                                   input reg_addr_t rd, rs1, rs2);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                   input reg_addr_t rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_s(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t enc_b(input logic [2:0] f3, input reg_addr_t rs1, rs2,
                                   input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t enc_u(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // integer ops as the ISA defines them
  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  //**************************************************
  // program building

  task automatic emit(input instr_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  task automatic op_r(input logic [2:0] f3, input logic alt, input reg_addr_t rd, rs1, rs2);
    emit(enc_r(f3, alt, rd, rs1, rs2));
    if (rd != 0) model[rd] = ref_alu(f3, alt, model[rs1], model[rs2]);
  endtask

  task automatic op_i(input logic [2:0] f3, input logic alt, input reg_addr_t rd, rs1,
                      input logic [11:0] imm);
    logic [11:0] field;
    word_t       b;
    field = imm;
    b = {{20{imm[11]}}, imm};
    // shifts carry shamt and the arithmetic bit in the immediate
    if (f3 == 3'd1 || f3 == 3'd5) begin
      field = {1'b0, alt, 5'b00000, imm[4:0]};
      b = {27'd0, imm[4:0]};
    end
    emit(enc_i(7'b0010011, f3, rd, rs1, field));
    if (rd != 0) model[rd] = ref_alu(f3, alt, model[rs1], b);
  endtask

  task automatic set_reg(input reg_addr_t rd, input word_t val);
    word_t upper;
    // round up so the sign-extended low part lands on val
    upper = val + 32'h800;
    emit(enc_u(rd, upper[31:12]));
    model[rd] = {upper[31:12], 12'h000};
    op_i(3'd0, 1'b0, rd, rd, val[11:0]);
  endtask

  task automatic st(input logic [2:0] f3, input reg_addr_t rs, input logic [11:0] addr);
    int n;
    int lane;
    n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
    emit(enc_s(f3, 5'd0, rs, addr));
    for (int i = 0; i < n; i++) begin
      lane = addr[1:0] + i;
      ref_mem[addr[11:2]][8*lane +: 8] = model[rs][8*i +: 8];
    end
  endtask

  task automatic ld(input logic [2:0] f3, input reg_addr_t rd, input logic [11:0] addr);
    word_t      w;
    logic [7:0] lo;
    logic [7:0] hi;
    w  = ref_mem[addr[11:2]];
    lo = w[8*addr[1:0] +: 8];
    hi = w[8*(addr[1:0] | 2'd1) +: 8];
    emit(enc_i(7'b0000011, f3, rd, 5'd0, addr));
    load_count++;
    case (f3)
      3'd0: model[rd] = {{24{lo[7]}}, lo};
      3'd4: model[rd] = {24'd0, lo};
      3'd1: model[rd] = {{16{hi[7]}}, hi, lo};
      3'd5: model[rd] = {16'd0, hi, lo};
      default: model[rd] = w;
    endcase
  endtask

  task automatic poke(input logic [11:0] addr, input word_t val);
    dmem[addr[11:2]] = val;
    ref_mem[addr[11:2]] = val;
  endtask

  // branch over two marker stores
  task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, rs2, input int k);
    logic [11:0] base;
    base = 12'h400 + 12'(8 * k);
    emit(enc_b(f3, rs1, rs2, 13'd12));
    if (ref_branch(f3, model[rs1], model[rs2])) begin
      emit(enc_s(3'd2, 5'd0, 5'd9, base));
      emit(enc_s(3'd2, 5'd0, 5'd9, base + 12'd4));
    end else begin
      st(3'd2, 5'd9, base);
      st(3'd2, 5'd9, base + 12'd4);
    end
  endtask

  //**************************************************
  // run control and checking

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_idle();
    check_word("dmem_read", {31'd0, dmem_read}, 32'd0);
    check_word("dmem_write", {31'd0, dmem_write}, 32'd0);
    check_word("imem_addr", imem_addr, `RESET_PC);
  endtask

  // holds the core in reset while memories are loaded
  task automatic begin_test();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    for (int i = 0; i < 256; i++) imem[i] = `NOP_INSTR;
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = fill_word(i);
      ref_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) model[i] = '0;
    prog_len = 0;
    load_count = 0;
  endtask

  task automatic run_program(input string name);
    bit seen;
    int reads;
    // sentinel sw x0, -4(x30) with x30 = 0x1000
    emit(enc_u(5'd30, 20'h00001));
    emit(enc_s(3'd2, 5'd30, 5'd0, 12'hffc));
    repeat (14) @(posedge clk);
    rst <= 1'b0;
    seen = 1'b0;
    reads = 0;
    for (int n = 0; n < 500 && !seen; n++) begin
      @(negedge clk);
      if (dmem_read) reads++;
      seen = dmem_write && (dmem_addr == 32'h0000_0ffc);
    end
    if (!seen) begin
      $display("%s: timed out waiting for the final store to 0xffc", name);
      test_errors++;
    end else begin
      // one read strobe cycle per load
      check_word("dmem_read cycles", reads, load_count);
      // last word holds the sentinel itself
      for (int i = 0; i < 1023; i++)
        check_word($sformatf("dmem[%h]", i * 4), dmem[i], ref_mem[i]);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    errors += test_errors;
    $display("%s test done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  //**************************************************
  // directed tests

  task automatic test_reset();
    begin_test();
    repeat (13) begin
      check_idle();
      @(posedge clk);
      @(negedge clk);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle();
    for (int i = 1; i <= 8; i++) begin
      @(negedge clk);
      check_word("imem_addr", imem_addr, `RESET_PC + 32'(4 * i));
    end
    end_test("reset");
  endtask

  task automatic test_alu();
    word_t r;
    int    k;
    for (int round = 0; round < 2; round++) begin
      begin_test();
      set_reg(5'd1, rand32());
      set_reg(5'd2, rand32());
      k = 0;
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if (alt == 0 || f3 == 0 || f3 == 5) begin
            op_r(f3[2:0], alt[0], 5'd3, 5'd1, 5'd2);
            st(3'd2, 5'd3, 12'h100 + 12'(4 * k));
            k++;
          end
          if (alt == 0 || f3 == 5) begin
            r = rand32();
            op_i(f3[2:0], alt[0], 5'd4, 5'd1, r[11:0]);
            st(3'd2, 5'd4, 12'h100 + 12'(4 * k));
            k++;
          end
        end
      end
      r = rand32();
      emit(enc_u(5'd5, r[31:12]));
      model[5] = {r[31:12], 12'h000};
      st(3'd2, 5'd5, 12'h100 + 12'(4 * k));
      // x0 stays zero whatever is written to it
      op_i(3'd0, 1'b0, 5'd0, 5'd1, 12'h5a5);
      op_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
      st(3'd2, 5'd0, 12'h1fc);
      run_program("alu");
    end
    end_test("alu");
  endtask

  task automatic test_forwarding();
    for (int round = 0; round < 2; round++) begin
      begin_test();
      set_reg(5'd1, rand32());
      set_reg(5'd2, rand32());
      op_r(3'd0, 1'b0, 5'd3, 5'd1, 5'd2);
      op_r(3'd0, 1'b1, 5'd4, 5'd3, 5'd1);
      op_r(3'd4, 1'b0, 5'd5, 5'd4, 5'd3);
      op_r(3'd6, 1'b0, 5'd6, 5'd5, 5'd4);
      op_r(3'd7, 1'b0, 5'd7, 5'd6, 5'd3);
      op_i(3'd0, 1'b0, 5'd3, 5'd7, 12'h8a1);
      op_r(3'd0, 1'b0, 5'd8, 5'd3, 5'd6);
      // same register in memory and writeback so the newer value must win
      op_i(3'd0, 1'b0, 5'd3, 5'd3, 12'h005);
      op_i(3'd0, 1'b0, 5'd3, 5'd3, 12'h007);
      op_r(3'd1, 1'b0, 5'd10, 5'd3, 5'd8);
      // x9 is never written here
      for (int i = 3; i <= 10; i++) begin
        if (i != 9) st(3'd2, i[4:0], 12'h200 + 12'(4 * i));
      end
      run_program("forwarding");
    end
    end_test("forwarding");
  endtask

  task automatic test_load_use();
    begin_test();
    poke(12'h300, rand32());
    poke(12'h304, rand32());
    set_reg(5'd2, rand32());
    ld(3'd2, 5'd1, 12'h300);
    op_r(3'd0, 1'b0, 5'd3, 5'd1, 5'd2);
    ld(3'd2, 5'd4, 12'h304);
    op_r(3'd0, 1'b1, 5'd5, 5'd2, 5'd4);
    ld(3'd1, 5'd6, 12'h306);
    op_i(3'd0, 1'b0, 5'd7, 5'd6, 12'h123);
    ld(3'd2, 5'd8, 12'h300);
    st(3'd2, 5'd8, 12'h320);
    st(3'd2, 5'd3, 12'h310);
    st(3'd2, 5'd5, 12'h314);
    st(3'd2, 5'd7, 12'h318);
    run_program("load_use");
    end_test("load_use");
  endtask

  task automatic test_subword();
    int          k;
    logic [11:0] a;
    begin_test();
    set_reg(5'd1, rand32());
    set_reg(5'd2, rand32());
    for (int i = 0; i < 4; i++) st(3'd0, (i % 2) ? 5'd2 : 5'd1, 12'h340 + 12'(5 * i));
    st(3'd1, 5'd2, 12'h350);
    st(3'd1, 5'd1, 12'h356);
    poke(12'h360, 32'h8f7f_80ff);
    poke(12'h364, rand32());
    k = 0;
    for (int w = 0; w < 2; w++) begin
      for (int off = 0; off < 4; off++) begin
        a = 12'h360 + 12'(4 * w + off);
        ld(3'd0, 5'd10, a);
        st(3'd2, 5'd10, 12'h380 + 12'(4 * k));
        ld(3'd4, 5'd11, a);
        st(3'd2, 5'd11, 12'h384 + 12'(4 * k));
        k += 2;
        if (off % 2 == 0) begin
          ld(3'd1, 5'd12, a);
          st(3'd2, 5'd12, 12'h380 + 12'(4 * k));
          ld(3'd5, 5'd13, a);
          st(3'd2, 5'd13, 12'h384 + 12'(4 * k));
          k += 2;
        end
      end
    end
    run_program("subword");
    end_test("subword");
  endtask

  task automatic test_branch();
    int k;
    begin_test();
    // opposite signs so signed and unsigned compares disagree
    set_reg(5'd1, rand32() | 32'h8000_0000);
    set_reg(5'd2, rand32() & 32'h7fff_ffff);
    set_reg(5'd9, 32'h5a5a_c3c3);
    k = 0;
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 != 2 && f3 != 3) begin
        branch_case(f3[2:0], 5'd1, 5'd2, k);
        branch_case(f3[2:0], 5'd2, 5'd1, k + 1);
        branch_case(f3[2:0], 5'd1, 5'd1, k + 2);
        k += 3;
      end
    end
    run_program("branch");
    end_test("branch");
  endtask

  initial begin
    rst = 1'b1;
    for (int i = 0; i < 256; i++) imem[i] = `NOP_INSTR;
    for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);
    test_reset();
    test_alu();
    test_forwarding();
    test_load_use();
    test_subword();
    test_branch();
    errors += i_rv_core.i_rv_core_chk.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv
